// File: hdl/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_AND = 3'd1,
        ALU_OR  = 3'd2,
        ALU_XOR = 3'd3
    } alu_op_e;

    typedef enum logic [1:0] {
        CARRY_ZERO = 2'b00,
        CARRY_ONE  = 2'b01,
        CARRY_FLAG = 2'b10     // carry in from P
    } carry_sel_e;

    // flag bit positions in P
    localparam int unsigned FLAG_N = 7;
    localparam int unsigned FLAG_V = 6;
    localparam int unsigned FLAG_D = 3;
    localparam int unsigned FLAG_I = 2;
    localparam int unsigned FLAG_Z = 1;
    localparam int unsigned FLAG_C = 0;

    // flags that take the alu result
    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } st_mask_t;

    localparam st_mask_t ST_NZ   = '{n: 1'b1, z: 1'b1, c: 1'b0, v: 1'b0};
    localparam st_mask_t ST_NZC  = '{n: 1'b1, z: 1'b1, c: 1'b1, v: 1'b0};
    localparam st_mask_t ST_NZCV = '{n: 1'b1, z: 1'b1, c: 1'b1, v: 1'b1};

    // set/clear requests from the flag instructions
    typedef struct packed {
        logic d;
        logic v;
        logic i;
        logic c;
    } flag_req_t;

    localparam logic [7:0] NOP_OPCODE = 8'hEA;

endpackage

`default_nettype wire

// File: hdl/cpu_ctrl_pkg.sv
`default_nettype none

package cpu_ctrl_pkg;

    import cpu_isa_pkg::*;

    typedef enum logic [1:0] {
        DB_DL = 2'd0,   // memory read data
        DB_AL = 2'd1,   // address low byte
        DB_Z  = 2'd2
    } db_src_e;

    // sb source and result destination
    typedef enum logic [2:0] {
        REG_A = 3'd0,
        REG_X = 3'd1,
        REG_Y = 3'd2,
        REG_D = 3'd3,   // memory write
        REG_Z = 3'd4    // nothing
    } reg_sel_e;

    typedef enum logic [1:0] {
        RES_DB  = 2'd0,
        RES_SB  = 2'd1,
        RES_ADD = 2'd2
    } res_src_e;

    typedef enum logic [3:0] {
        BOOT   = 4'd0,
        T0     = 4'd1,
        T1     = 4'd2,
        T2_ZPG = 4'd3,
        T2_ABS = 4'd4,
        T3_ABS = 4'd5,
        JAM    = 4'd6
    } cpu_state_e;

    typedef struct packed {
        db_src_e    db_src;
        reg_sel_e   sb_src;
        res_src_e   res_src;
        reg_sel_e   res_dst;
        alu_op_e    alu_op;
        logic       inv_ai;
        logic       inv_bi;
        carry_sel_e carry_sel;
        st_mask_t   st_mask;
        flag_req_t  set_mask;
        flag_req_t  clr_mask;
    } ex_ctrl_t;

    // does nothing to registers, memory or flags
    localparam ex_ctrl_t EX_NOP = '{
        db_src:    DB_DL,
        sb_src:    REG_Z,
        res_src:   RES_ADD,
        res_dst:   REG_Z,
        alu_op:    ALU_ADD,
        inv_ai:    1'b0,
        inv_bi:    1'b0,
        carry_sel: CARRY_ZERO,
        st_mask:   '0,
        set_mask:  '0,
        clr_mask:  '0
    };

endpackage

`default_nettype wire

// File: hdl/cpu_ctrl_if.sv
`timescale 1ns/100ps
`default_nettype none

interface cpu_ctrl_if
    import cpu_isa_pkg::*, cpu_ctrl_pkg::*;
();

    db_src_e    db_src;
    reg_sel_e   sb_src;
    alu_op_e    alu_op;
    logic       inv_ai;
    logic       inv_bi;
    carry_sel_e carry_sel;
    st_mask_t   st_mask;
    flag_req_t  set_mask;
    flag_req_t  clr_mask;
    res_src_e   res_src;
    reg_sel_e   res_dst;

    modport seq (
        output db_src, sb_src, alu_op, inv_ai, inv_bi, carry_sel,
        output st_mask, set_mask, clr_mask, res_src, res_dst
    );

    modport dp (
        input db_src, sb_src, alu_op, inv_ai, inv_bi, carry_sel,
        input st_mask, set_mask, clr_mask, res_src, res_dst
    );

endinterface

`default_nettype wire

// File: hdl/cpu_alu.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_alu
    import cpu_isa_pkg::*;
(
    input  wire logic [7:0] i_sb,
    input  wire logic [7:0] i_db,
    input  wire alu_op_e    i_op,
    input  wire logic       i_inv_ai,
    input  wire logic       i_inv_bi,
    input  wire logic       i_carry_in,
    output logic [7:0]      o_result,
    output logic            o_n,
    output logic            o_z,
    output logic            o_c,
    output logic            o_v
);

    logic [7:0] ai;
    logic [7:0] bi;
    logic       cout;

    always_comb begin
        ai   = i_inv_ai ? ~i_sb : i_sb;
        bi   = i_inv_bi ? ~i_db : i_db;   // subtract is add of ~db with carry set
        cout = 1'b0;
        case (i_op)
            ALU_ADD: {cout, o_result} = {1'b0, ai} + {1'b0, bi} + {8'd0, i_carry_in};
            ALU_AND: o_result = ai & bi;
            ALU_OR:  o_result = ai | bi;
            ALU_XOR: o_result = ai ^ bi;
            default: o_result = 8'h00;
        endcase
    end

    assign o_n = o_result[7];
    assign o_z = (o_result == 8'h00);
    assign o_c = cout;
    // carry into bit 7 xor carry out of bit 7
    assign o_v = ai[7] ^ bi[7] ^ o_result[7] ^ cout;

endmodule

`default_nettype wire

// File: hdl/cpu_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_datapath
    import cpu_isa_pkg::*, cpu_ctrl_pkg::*;
(
    input  wire logic       i_clk,
    input  wire logic       i_rst,
    input  wire logic [7:0] i_data,
    cpu_ctrl_if.dp          ctrl,
    input  wire logic [7:0] i_addr_lo,
    output logic [7:0]      o_db,
    output logic [7:0]      o_res,
    output logic [7:0]      o_wdata,
    output logic            o_we,
    output logic [7:0]      o_status
);

    logic [7:0] a;
    logic [7:0] x;
    logic [7:0] y;
    logic [7:0] p;
    logic [7:0] sb;
    logic [7:0] alu_out;
    logic [7:0] add;                        // result latch
    logic       alu_n, alu_z, alu_c, alu_v;
    logic       add_n, add_z, add_c, add_v; // flags held with the result
    logic       carry_in;

    always_comb begin
        case (ctrl.db_src)
            DB_DL:   o_db = i_data;
            DB_AL:   o_db = i_addr_lo;
            default: o_db = 8'h00;
        endcase
        case (ctrl.sb_src)
            REG_A:   sb = a;
            REG_X:   sb = x;
            REG_Y:   sb = y;
            default: sb = 8'h00;
        endcase
        case (ctrl.res_src)
            RES_DB:  o_res = o_db;
            RES_SB:  o_res = sb;
            RES_ADD: o_res = add;
            default: o_res = 8'h00;
        endcase
        case (ctrl.carry_sel)
            CARRY_ONE:  carry_in = 1'b1;
            CARRY_FLAG: carry_in = p[FLAG_C];
            default:    carry_in = 1'b0;
        endcase
    end

    cpu_alu u_alu (
        .i_sb       (sb),
        .i_db       (o_db),
        .i_op       (ctrl.alu_op),
        .i_inv_ai   (ctrl.inv_ai),
        .i_inv_bi   (ctrl.inv_bi),
        .i_carry_in (carry_in),
        .o_result   (alu_out),
        .o_n        (alu_n),
        .o_z        (alu_z),
        .o_c        (alu_c),
        .o_v        (alu_v)
    );

    // computed in one cycle, saved in the next
    always_ff @(posedge i_clk) begin
        add <= alu_out;
        {add_n, add_z, add_c, add_v} <= {alu_n, alu_z, alu_c, alu_v};
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            a <= 8'h00;
            x <= 8'h00;
            y <= 8'h00;
            p <= 8'h00;
        end else begin
            case (ctrl.res_dst)
                REG_A:   a <= o_res;
                REG_X:   x <= o_res;
                REG_Y:   y <= o_res;
                default: ;
            endcase
            // clear wins over set, set wins over alu flag
            p[FLAG_N] <= ctrl.st_mask.n ? add_n : p[FLAG_N];
            p[FLAG_V] <= ctrl.clr_mask.v ? 1'b0 :
                         ctrl.set_mask.v ? 1'b1 :
                         ctrl.st_mask.v  ? add_v : p[FLAG_V];
            p[FLAG_D] <= ctrl.clr_mask.d ? 1'b0 : ctrl.set_mask.d ? 1'b1 : p[FLAG_D];
            p[FLAG_I] <= ctrl.clr_mask.i ? 1'b0 : ctrl.set_mask.i ? 1'b1 : p[FLAG_I];
            p[FLAG_Z] <= ctrl.st_mask.z ? add_z : p[FLAG_Z];
            p[FLAG_C] <= ctrl.clr_mask.c ? 1'b0 :
                         ctrl.set_mask.c ? 1'b1 :
                         ctrl.st_mask.c  ? add_c : p[FLAG_C];
        end
    end

    assign o_we     = (ctrl.res_dst == REG_D);
    assign o_wdata  = o_res;
    assign o_status = p;

endmodule

`default_nettype wire

// File: hdl/cpu_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_decoder
    import cpu_isa_pkg::*, cpu_ctrl_pkg::*;
(
    input  wire logic       i_clk,
    input  wire logic       i_rst,
    input  wire logic [7:0] i_data,
    input  wire logic       i_fetch,
    output ex_ctrl_t        o_ex,
    output cpu_state_e      o_init_state,
    output logic            o_single_byte
);

    logic [7:0] ir;
    logic [7:0] cur_op;
    logic [2:0] op_a;
    logic [2:0] op_b;
    logic [1:0] op_c;
    ex_ctrl_t   ex_next;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ir <= NOP_OPCODE;
        end else if (i_fetch) begin
            ir <= i_data;
        end
    end

    // opcode arrives on the bus in T1, before ir has it
    assign cur_op = i_fetch ? i_data : ir;
    assign {op_a, op_b, op_c} = cur_op;

    // addressing mode
    always_comb begin
        o_init_state  = JAM;
        o_single_byte = 1'b0;
        if (op_c == 2'd1) begin
            case (op_b)
                3'd1:    o_init_state = T2_ZPG;
                3'd2:    o_init_state = (op_a == 3'd4) ? JAM : T0;  // no STA #imm
                3'd3:    o_init_state = T2_ABS;
                default: o_init_state = JAM;
            endcase
        end else if (op_c == 2'd0 && (op_b == 3'd6 || (op_b == 3'd2 && op_a[2]))) begin
            o_init_state  = T0;    // implied
            o_single_byte = 1'b1;
        end
    end

    always_comb begin
        ex_next = EX_NOP;
        if (op_c == 2'd1) begin
            // accumulator group, A op mem -> A
            ex_next.sb_src  = REG_A;
            ex_next.res_dst = REG_A;
            case (op_a)
                3'd0: begin
                    ex_next.alu_op  = ALU_OR;
                    ex_next.st_mask = ST_NZ;
                end
                3'd1: begin
                    ex_next.alu_op  = ALU_AND;
                    ex_next.st_mask = ST_NZ;
                end
                3'd2: begin
                    ex_next.alu_op  = ALU_XOR;
                    ex_next.st_mask = ST_NZ;
                end
                3'd3: begin
                    ex_next.carry_sel = CARRY_FLAG;
                    ex_next.st_mask   = ST_NZCV;
                end
                3'd4: begin                    // STA
                    ex_next.res_src = RES_SB;
                    ex_next.res_dst = REG_D;
                end
                3'd5: begin                    // LDA as 0 + mem
                    ex_next.sb_src  = REG_Z;
                    ex_next.st_mask = ST_NZ;
                end
                3'd6: begin                    // CMP, flags only
                    ex_next.inv_bi    = 1'b1;
                    ex_next.carry_sel = CARRY_ONE;
                    ex_next.st_mask   = ST_NZC;
                    ex_next.res_dst   = REG_Z;
                end
                default: begin                 // SBC
                    ex_next.inv_bi    = 1'b1;
                    ex_next.carry_sel = CARRY_FLAG;
                    ex_next.st_mask   = ST_NZCV;
                end
            endcase
        end else if (op_c == 2'd0 && op_b == 3'd6) begin
            case (op_a)
                3'd0: ex_next.clr_mask.c = 1'b1;
                3'd1: ex_next.set_mask.c = 1'b1;
                3'd2: ex_next.clr_mask.i = 1'b1;
                3'd3: ex_next.set_mask.i = 1'b1;
                3'd4: begin                    // TYA
                    ex_next.sb_src  = REG_Y;
                    ex_next.res_src = RES_SB;
                    ex_next.res_dst = REG_A;
                    ex_next.db_src  = DB_Z;    // alu sees y + 0 for the flags
                    ex_next.st_mask = ST_NZ;
                end
                3'd5: ex_next.clr_mask.v = 1'b1;
                3'd6: ex_next.clr_mask.d = 1'b1;
                default: ex_next.set_mask.d = 1'b1;
            endcase
        end else if (op_c == 2'd0 && op_b == 3'd2 && op_a[2]) begin
            if (op_a == 3'd5) begin            // TAY
                ex_next.sb_src  = REG_A;
                ex_next.res_src = RES_SB;
                ex_next.res_dst = REG_Y;
                ex_next.db_src  = DB_Z;        // alu sees a + 0 for the flags
                ex_next.st_mask = ST_NZ;
            end else begin
                // DEY adds ff, INY and INX add carry
                ex_next.sb_src    = (op_a == 3'd7) ? REG_X : REG_Y;
                ex_next.res_dst   = (op_a == 3'd7) ? REG_X : REG_Y;
                ex_next.db_src    = DB_Z;
                ex_next.inv_bi    = (op_a == 3'd4);
                ex_next.carry_sel = (op_a == 3'd4) ? CARRY_ZERO : CARRY_ONE;
                ex_next.st_mask   = ST_NZ;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_ex <= EX_NOP;
        end else begin
            o_ex <= ex_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/cpu_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_sequencer
    import cpu_isa_pkg::*, cpu_ctrl_pkg::*;
#(
    parameter logic [15:0] BOOT_ADDR = 16'h0200
) (
    input  wire logic       i_clk,
    input  wire logic       i_rst,
    input  wire ex_ctrl_t   i_ex,
    input  wire cpu_state_e i_init_state,
    input  wire logic       i_single_byte,
    input  wire logic [7:0] i_res,
    input  wire logic [7:0] i_db,
    output logic [15:0]     o_addr,
    output logic            o_fetch,
    output logic            o_sync,
    cpu_ctrl_if.seq         ctrl
);

    cpu_state_e  state;
    logic [15:0] pc;
    logic [7:0]  adl;      // absolute low byte
    logic        inc_pc;
    logic        store;
    logic        compute;
    logic        save;

    assign store   = (i_ex.res_dst == REG_D);
    assign o_fetch = (state == T1);
    assign o_sync  = (state == T0);

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= BOOT;
        end else begin
            case (state)
                BOOT:    state <= T0;
                T0:      state <= T1;
                T1:      state <= i_init_state;
                T2_ABS:  state <= T3_ABS;
                T2_ZPG,
                T3_ABS:  state <= T0;
                default: state <= JAM;  // stuck until reset
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            pc <= BOOT_ADDR;
        end else if (inc_pc) begin
            pc <= pc + 16'd1;
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == T2_ABS) adl <= i_res;  // low operand passed through db
    end

    always_comb begin
        o_addr  = pc;
        inc_pc  = 1'b0;
        compute = 1'b0;
        save    = 1'b0;
        case (state)
            T0: begin
                inc_pc  = 1'b1;
                compute = !store;       // stores already done
            end
            T1: begin
                inc_pc = !i_single_byte;
                save   = !store;
            end
            T2_ZPG: begin
                o_addr = {8'h00, i_db};
                save   = store;
            end
            T2_ABS: inc_pc = 1'b1;     // fetch high byte
            T3_ABS: begin
                o_addr = {i_db, adl};
                save   = store;
            end
            default: ;
        endcase
    end

    // outside compute/save: db passes straight to res, nothing written
    always_comb begin
        ctrl.db_src    = DB_DL;
        ctrl.sb_src    = REG_Z;
        ctrl.alu_op    = ALU_ADD;
        ctrl.inv_ai    = 1'b0;
        ctrl.inv_bi    = 1'b0;
        ctrl.carry_sel = CARRY_ZERO;
        ctrl.st_mask   = '0;
        ctrl.set_mask  = '0;
        ctrl.clr_mask  = '0;
        ctrl.res_src   = RES_DB;
        ctrl.res_dst   = REG_Z;
        if (compute || save) begin
            ctrl.db_src = i_ex.db_src;
            ctrl.sb_src = i_ex.sb_src;
        end
        if (compute) begin
            ctrl.alu_op    = i_ex.alu_op;
            ctrl.inv_ai    = i_ex.inv_ai;
            ctrl.inv_bi    = i_ex.inv_bi;
            ctrl.carry_sel = i_ex.carry_sel;
        end
        if (save) begin
            ctrl.st_mask  = i_ex.st_mask;
            ctrl.set_mask = i_ex.set_mask;
            ctrl.clr_mask = i_ex.clr_mask;
            ctrl.res_src  = i_ex.res_src;
            ctrl.res_dst  = i_ex.res_dst;
        end
    end

endmodule

`default_nettype wire

// File: hdl/cpu_core.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_core
    import cpu_ctrl_pkg::*;
#(
    parameter logic [15:0] BOOT_ADDR = 16'h0200
) (
    input  wire logic       i_clk,
    input  wire logic       i_rst,
    input  wire logic [7:0] i_data,
    output logic [15:0]     o_addr,
    output logic [7:0]      o_wdata,
    output logic            o_we,
    output logic            o_sync,
    output logic [7:0]      o_status
);

    cpu_ctrl_if ctrl_if ();

    ex_ctrl_t   ex;
    cpu_state_e init_state;
    logic       single_byte;
    logic       fetch;
    logic [7:0] db;
    logic [7:0] res;

    cpu_decoder u_decoder (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_data        (i_data),
        .i_fetch       (fetch),
        .o_ex          (ex),
        .o_init_state  (init_state),
        .o_single_byte (single_byte)
    );

    cpu_sequencer #(
        .BOOT_ADDR (BOOT_ADDR)
    ) u_sequencer (
        .i_clk         (i_clk),
        .i_rst         (i_rst),
        .i_ex          (ex),
        .i_init_state  (init_state),
        .i_single_byte (single_byte),
        .i_res         (res),
        .i_db          (db),
        .o_addr        (o_addr),
        .o_fetch       (fetch),
        .o_sync        (o_sync),
        .ctrl          (ctrl_if.seq)
    );

    cpu_datapath u_datapath (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .i_data    (i_data),
        .ctrl      (ctrl_if.dp),
        .i_addr_lo (o_addr[7:0]),
        .o_db      (db),
        .o_res     (res),
        .o_wdata   (o_wdata),
        .o_we      (o_we),
        .o_status  (o_status)
    );

endmodule

`default_nettype wire

// File: verif/cpu_mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_mem_model (
    input  wire logic        i_clk,
    input  wire logic [15:0] i_addr,
    input  wire logic [7:0]  i_wdata,
    input  wire logic        i_we,
    output logic [7:0]       o_rdata
);

    // program image, written by the testbench between runs
    logic [7:0] mem [0:65535];

    initial o_rdata = 8'h00;

    // registered read, old data on a write to the same address
    always @(posedge i_clk) begin
        if (i_we) begin
            mem[i_addr] <= i_wdata;
        end
        o_rdata <= mem[i_addr];
    end

    // background bytes depend on both address halves
    task automatic fill_pattern();
        int a;
        for (a = 0; a < 65536; a++) begin
            mem[a] = a[15:8] ^ a[7:0] ^ 8'h5a;
        end
    endtask

endmodule

`default_nettype wire

// File: verif/tb_cpu_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cpu_core
    import cpu_isa_pkg::*;
();

    localparam logic [15:0] BOOT_ADDR = 16'h0400;
    localparam int CLK_PERIOD = 10;
    localparam int RST_CYCLES = 16;
    // instructions per program times programs, jam opcodes included
    localparam int TOTAL_INSTR = 10 * 5 + 2 * 3 + 3 * 4 + 2 * 9 + 2 * 9 + 3;
    localparam int WATCHDOG_CYCLES = 40 * TOTAL_INSTR;

    logic        clk;
    logic        rst;
    logic [7:0]  mem_rdata;
    logic [15:0] addr;
    logic [7:0]  wdata;
    logic        we;
    logic        sync;
    logic [7:0]  status;

    integer      seed;
    string       test_name;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    logic [15:0] pc_img;       // next free byte of the program image
    logic [7:0]  m_a;
    logic [7:0]  m_x;
    logic [7:0]  m_y;
    logic [7:0]  m_p;
    logic [15:0] res_addr;
    logic [7:0]  exp_data;
    logic        expect_store;
    logic        store_seen;
    logic        first_fetch;
    logic        jammed;

    cpu_core #(
        .BOOT_ADDR (BOOT_ADDR)
    ) u_cpu_core (
        .i_clk    (clk),
        .i_rst    (rst),
        .i_data   (mem_rdata),
        .o_addr   (addr),
        .o_wdata  (wdata),
        .o_we     (we),
        .o_sync   (sync),
        .o_status (status)
    );

    cpu_mem_model u_mem (
        .i_clk   (clk),
        .i_addr  (addr),
        .i_wdata (wdata),
        .i_we    (we),
        .o_rdata (mem_rdata)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic log_failure(input string msg);
        $display("%s", msg);
        test_errors++;
    endtask

    // bus checks, sampled before this edge's updates land
    always @(posedge clk) begin
        if (!rst) begin
            if (sync && first_fetch) begin
                assert (addr == BOOT_ADDR) else log_failure($sformatf(
                    "CHECK FAILED %s: first fetch expected %04h, actual %04h",
                    test_name, BOOT_ADDR, addr));
                first_fetch <= 1'b0;
            end
            if (we) begin
                assert (expect_store && !store_seen && addr == res_addr) else log_failure(
                    $sformatf("%s: unexpected write of %02h to %04h", test_name, wdata, addr));
                if (addr == res_addr) begin
                    assert (wdata == exp_data) else log_failure($sformatf(
                        "CHECK FAILED %s: store expected %02h, actual %02h",
                        test_name, exp_data, wdata));
                end
                store_seen <= 1'b1;
            end
            assert (!(jammed && sync)) else log_failure(
                $sformatf("%s: opcode fetch after the core had jammed", test_name));
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, a test never finished", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

    task automatic set_nz(input logic [7:0] v);
        m_p[FLAG_N] = v[7];
        m_p[FLAG_Z] = (v == 8'h00);
    endtask

    // binary add with carry, overflow when both signs agree and the sum flips
    task automatic add_model(input logic [7:0] b);
        logic [8:0] sum;
        sum = {1'b0, m_a} + {1'b0, b} + {8'd0, m_p[FLAG_C]};
        m_p[FLAG_V] = (m_a[7] == b[7]) && (sum[7] != m_a[7]);
        m_p[FLAG_C] = sum[8];
        m_a = sum[7:0];
        set_nz(m_a);
    endtask

    task automatic exec_acc(input logic [2:0] grp, input logic [7:0] m, input logic [15:0] ea);
        case (grp)
            3'd0: begin
                m_a = m_a | m;
                set_nz(m_a);
            end
            3'd1: begin
                m_a = m_a & m;
                set_nz(m_a);
            end
            3'd2: begin
                m_a = m_a ^ m;
                set_nz(m_a);
            end
            3'd3: add_model(m);
            3'd4: begin
                expect_store = 1'b1;
                res_addr     = ea;
                exp_data     = m_a;
            end
            3'd5: begin
                m_a = m;
                set_nz(m_a);
            end
            3'd6: begin
                m_p[FLAG_C] = (m_a >= m);
                set_nz(m_a - m);
            end
            default: add_model(~m);
        endcase
    endtask

    task automatic emit(input logic [7:0] b);
        u_mem.mem[pc_img] = b;
        pc_img = pc_img + 16'd1;
    endtask

    task automatic acc_imm(input logic [2:0] grp, input logic [7:0] v);
        emit({grp, 3'd2, 2'b01});
        emit(v);
        exec_acc(grp, v, 16'h0000);
    endtask

    task automatic acc_zpg(input logic [2:0] grp, input logic [7:0] zp);
        emit({grp, 3'd1, 2'b01});
        emit(zp);
        exec_acc(grp, u_mem.mem[{8'h00, zp}], {8'h00, zp});
    endtask

    task automatic acc_abs(input logic [2:0] grp, input logic [15:0] ea);
        emit({grp, 3'd3, 2'b01});
        emit(ea[7:0]);
        emit(ea[15:8]);
        exec_acc(grp, u_mem.mem[ea], ea);
    endtask

    task automatic implied(input logic [7:0] op);
        emit(op);
        case (op)
            8'h18: m_p[FLAG_C] = 1'b0;
            8'h38: m_p[FLAG_C] = 1'b1;
            8'h58: m_p[FLAG_I] = 1'b0;
            8'h78: m_p[FLAG_I] = 1'b1;
            8'hb8: m_p[FLAG_V] = 1'b0;
            8'hd8: m_p[FLAG_D] = 1'b0;
            8'hf8: m_p[FLAG_D] = 1'b1;
            8'h98: begin           // tya
                m_a = m_y;
                set_nz(m_a);
            end
            8'ha8: begin           // tay
                m_y = m_a;
                set_nz(m_y);
            end
            8'h88: begin
                m_y = m_y - 8'd1;
                set_nz(m_y);
            end
            8'hc8: begin
                m_y = m_y + 8'd1;
                set_nz(m_y);
            end
            8'he8: begin
                m_x = m_x + 8'd1;
                set_nz(m_x);
            end
            default: ;             // jam opcodes
        endcase
    endtask

    task automatic start_test(input string name);
        @(negedge clk);
        rst          = 1'b1;
        test_name    = name;
        test_errors  = 0;
        expect_store = 1'b0;
        store_seen   = 1'b0;
        first_fetch  = 1'b1;
        jammed       = 1'b0;
        u_mem.fill_pattern();
        pc_img = BOOT_ADDR;
        m_a    = 8'h00;
        m_x    = 8'h00;
        m_y    = 8'h00;
        m_p    = 8'h00;
    endtask

    task automatic finish_test();
        int quiet;
        repeat (RST_CYCLES) @(negedge clk);
        rst   = 1'b0;
        quiet = 0;
        while (quiet < 8) begin    // halted once no fetch for 8 cycles
            @(negedge clk);
            quiet = sync ? 0 : quiet + 1;
        end
        jammed = 1'b1;
        repeat (16) @(negedge clk);
        if (expect_store && !store_seen) begin
            log_failure($sformatf("%s: no store to %04h, the core stopped early",
                test_name, res_addr));
        end
        assert (status == m_p) else log_failure($sformatf(
            "CHECK FAILED %s: status expected %02h, actual %02h", test_name, m_p, status));
        tests_run++;
        if (test_errors == 0) begin
            $display("PASS %s", test_name);
        end else begin
            $display("FAIL %s", test_name);
            tests_failed++;
        end
    endtask

    function automatic string acc_name(input logic [2:0] grp);
        case (grp)
            3'd0:    return "ora";
            3'd1:    return "and";
            3'd2:    return "eor";
            3'd3:    return "adc";
            default: return "sbc";
        endcase
    endfunction

    initial begin
        logic [2:0] alu_grp [5];
        logic [7:0] r1;
        logic [7:0] r2;
        logic       cin;
        int         i;
        alu_grp      = '{3'd0, 3'd1, 3'd2, 3'd3, 3'd7};
        seed         = 32'h8029_ede0;
        rst          = 1'b1;
        tests_run    = 0;
        tests_failed = 0;
        test_errors  = 0;
        test_name    = "reset";
        expect_store = 1'b0;
        store_seen   = 1'b0;
        first_fetch  = 1'b1;
        jammed       = 1'b0;
        res_addr     = 16'h0000;
        exp_data     = 8'h00;

        for (i = 0; i < 10; i++) begin
            r1  = $random(seed);
            r2  = $random(seed);
            cin = $random(seed);
            start_test($sformatf("imm_%s_%0d", acc_name(alu_grp[i % 5]), i / 5));
            implied(cin ? 8'h38 : 8'h18);
            acc_imm(3'd5, r1);
            acc_imm(alu_grp[i % 5], r2);
            acc_zpg(3'd4, 8'h80);
            implied(8'h02);
            finish_test();
        end

        r1 = $random(seed);
        start_test("lda_zpg");
        u_mem.mem[16'h0040] = r1;
        acc_zpg(3'd5, 8'h40);
        acc_abs(3'd4, 16'h0300);
        implied(8'h02);
        finish_test();

        r1 = $random(seed);
        start_test("lda_abs");
        u_mem.mem[16'h1234] = r1;
        acc_abs(3'd5, 16'h1234);
        acc_abs(3'd4, 16'h0300);
        implied(8'h02);
        finish_test();

        // equal, below and above
        for (i = 0; i < 3; i++) begin
            r1 = $random(seed);
            r2 = $random(seed);
            case (i)
                0: r2 = r1;
                1: begin
                    r1[7] = 1'b0;
                    r2[7] = 1'b1;
                end
                default: begin
                    r1[7] = 1'b1;
                    r2[7] = 1'b0;
                end
            endcase
            start_test($sformatf("cmp_%0d", i));
            acc_imm(3'd5, r1);
            acc_imm(3'd6, r2);
            acc_zpg(3'd4, 8'h80);
            implied(8'h02);
            finish_test();
        end

        for (i = 0; i < 2; i++) begin
            r1 = (i == 0) ? 8'hff : 8'($random(seed));    // ff wraps y through zero
            start_test($sformatf("reg_chain_%0d", i));
            acc_imm(3'd5, r1);
            implied(8'ha8);
            implied(8'he8);
            implied(8'hc8);
            implied(8'hc8);
            implied(8'h88);
            implied(8'h98);
            acc_zpg(3'd4, 8'h80);
            implied(8'h02);
            finish_test();
        end

        r1 = $random(seed);
        r2 = $random(seed);
        for (i = 0; i < 2; i++) begin
            start_test(i == 0 ? "flags_sec" : "flags_clc");
            implied(8'hf8);
            implied(8'h78);
            implied(8'h58);
            implied(i == 0 ? 8'h38 : 8'h18);
            acc_imm(3'd5, r1);
            acc_imm(3'd3, r2);
            implied(8'hb8);
            acc_zpg(3'd4, 8'h80);
            implied(8'h02);
            finish_test();
        end

        r1 = $random(seed);
        start_test("branch_jam");
        acc_imm(3'd5, r1);
        emit(8'hd0);               // bne, outside the kept set
        emit(8'h85);               // sta zp that must never run
        emit(8'h80);
        finish_test();

        $display("tests run: %0d, passed: %0d, failed: %0d",
            tests_run, tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
hdl/cpu_isa_pkg.sv
hdl/cpu_ctrl_pkg.sv
hdl/cpu_ctrl_if.sv
hdl/cpu_alu.sv
hdl/cpu_datapath.sv
hdl/cpu_decoder.sv
hdl/cpu_sequencer.sv
hdl/cpu_core.sv
verif/cpu_mem_model.sv
verif/tb_cpu_core.sv
